/* Bender.yml */
package:
  name: vstu

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/vstu_pkg.sv
      - hdl/lane_spill_reg.sv
      - hdl/store_insn_queue.sv
      - hdl/w_beat_builder.sv
      - hdl/vstu_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/vstu_asserts.sv
      - verif/vstu_tb.sv

/* all.f */
+incdir+hdl
hdl/vstu_pkg.sv
hdl/lane_spill_reg.sv
hdl/store_insn_queue.sv
hdl/w_beat_builder.sv
hdl/vstu_top.sv
verif/vstu_asserts.sv
verif/vstu_tb.sv

/* hdl/lane_spill_reg.sv */
/*
 * Fall-through holding register for one lane
 * Separate entries for the operand word and its mask byte enables
 */
`timescale 1ns/1ps

module lane_spill_reg (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // Lane side
  input  vstu_pkg::elen_t      operand_i,
  input  vstu_pkg::lane_strb_t mask_i,
  input  logic                 operand_valid_i,
  input  logic                 mask_valid_i,
  output logic                 operand_ready_o,
  output logic                 mask_ready_o,
  // Beat builder side
  output vstu_pkg::elen_t      operand_o,
  output vstu_pkg::lane_strb_t mask_o,
  output logic                 operand_valid_o,
  output logic                 mask_valid_o,
  input  logic                 pop_i
);

  logic operand_load, mask_load;

  // Room when empty, or when the builder drains it this cycle
  assign operand_ready_o = !operand_valid_o || pop_i;
  assign mask_ready_o    = !mask_valid_o || pop_i;

  assign operand_load = operand_valid_i && operand_ready_o;
  assign mask_load    = mask_valid_i && mask_ready_o;

  // Valid bits, flush drops whatever is held
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      operand_valid_o <= 1'b0;
      mask_valid_o    <= 1'b0;
    end else if (flush_i) begin
      operand_valid_o <= 1'b0;
      mask_valid_o    <= 1'b0;
    end else begin
      if (operand_load || pop_i) operand_valid_o <= operand_load;
      if (mask_load || pop_i)    mask_valid_o    <= mask_load;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (operand_load) operand_o <= operand_i;
    if (mask_load)    mask_o    <= mask_i;
  end

endmodule

/* hdl/store_insn_queue.sv */
/*
 * Store instruction queue
 * Accept, issue and commit pointers over a small instruction array,
 * B-response commit and the registered done response to the sequencer
 */
`timescale 1ns/1ps
`include "vstu_params.svh"

module store_insn_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Sequencer request
  input  logic                  pe_req_valid_i,
  input  vstu_pkg::vid_t        pe_req_id_i,
  input  vstu_pkg::vfu_e        pe_req_vfu_i,
  input  vstu_pkg::vlen_t       pe_req_vl_i,
  input  vstu_pkg::vsew_e       pe_req_vsew_i,
  input  logic                  pe_req_vm_i,
  output logic                  pe_req_ready_o,
  // Oldest unissued instruction
  output logic                  issue_valid_o,
  output vstu_pkg::vlen_t       issue_vl_o,
  output vstu_pkg::vsew_e       issue_vsew_o,
  output logic                  issue_vm_o,
  input  logic                  issue_done_i,
  // B channel
  input  logic                  b_valid_i,
  output logic                  b_ready_o,
  // Status and response
  output logic                  store_pending_o,
  output logic                  store_complete_o,
  output vstu_pkg::vinsn_mask_t pe_resp_vinsn_done_o
);

  localparam int unsigned Depth = `VSTU_INSN_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);
  localparam int unsigned CntW  = PntW + 1;

  // Instruction array, payload only
  vstu_pkg::vid_t  id_q   [Depth];
  vstu_pkg::vlen_t vl_q   [Depth];
  vstu_pkg::vsew_e vsew_q [Depth];
  logic            vm_q   [Depth];

  // Accept, issue and commit positions
  logic [PntW-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Instructions still to issue, and still to commit
  logic [CntW-1:0] issue_cnt_q, commit_cnt_q;

  logic accept, b_hs;

  function automatic logic [PntW-1:0] next_pnt(input logic [PntW-1:0] pnt);
    return (pnt == PntW'(Depth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////////////////////////

  assign pe_req_ready_o = (commit_cnt_q != CntW'(Depth));
  // Requests for other units pass by untouched
  assign accept = pe_req_valid_i && pe_req_ready_o &&
                  (pe_req_vfu_i == vstu_pkg::VFU_STORE);

  // Done issuing but not yet acknowledged
  assign b_ready_o        = (commit_cnt_q != issue_cnt_q);
  assign b_hs             = b_valid_i && b_ready_o;
  assign store_complete_o = b_hs;
  assign store_pending_o  = (commit_cnt_q != '0);

  // Issue view of the oldest unissued entry
  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_vl_o    = vl_q[issue_pnt_q];
  assign issue_vsew_o  = vsew_q[issue_pnt_q];
  assign issue_vm_o    = vm_q[issue_pnt_q];

  //////////////////////////////////////////////////////////////////////
  // Queue state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q         <= '0;
      issue_pnt_q          <= '0;
      commit_pnt_q         <= '0;
      issue_cnt_q          <= '0;
      commit_cnt_q         <= '0;
      pe_resp_vinsn_done_o <= '0;
    end else begin
      if (accept)       accept_pnt_q <= next_pnt(accept_pnt_q);
      if (issue_done_i) issue_pnt_q  <= next_pnt(issue_pnt_q);
      if (b_hs)         commit_pnt_q <= next_pnt(commit_pnt_q);
      issue_cnt_q  <= issue_cnt_q + CntW'(accept) - CntW'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + CntW'(accept) - CntW'(b_hs);
      // One-cycle done bit for the ID that just committed
      pe_resp_vinsn_done_o <= b_hs ? vstu_pkg::vinsn_mask_t'(1) << id_q[commit_pnt_q] : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q[accept_pnt_q]   <= pe_req_id_i;
      vl_q[accept_pnt_q]   <= pe_req_vl_i;
      vsew_q[accept_pnt_q] <= pe_req_vsew_i;
      vm_q[accept_pnt_q]   <= pe_req_vm_i;
    end
  end

endmodule

/* hdl/vstu_params.svh */
/*
 * Build-time constants of the vector store unit
 * Lane geometry, queue sizing and counter widths
 */
`ifndef VSTU_PARAMS_SVH
`define VSTU_PARAMS_SVH

// Lanes feeding one W beat
`define VSTU_NR_LANES 4
// Bits per lane element
`define VSTU_ELEN 64
// Bytes carried by one lane word
`define VSTU_LANE_BYTES (`VSTU_ELEN / 8)
// Bytes per W beat, all lanes side by side
`define VSTU_BEAT_BYTES (`VSTU_NR_LANES * `VSTU_LANE_BYTES)

// In-flight store instructions
`define VSTU_INSN_DEPTH 4
// Instruction IDs handed out by the sequencer
`define VSTU_NR_VINSN 8

// Vector length field
`define VSTU_VL_W 8
// Byte count, enough for 255 elements of 8 bytes
`define VSTU_BYTE_CNT_W 12

`endif

/* hdl/vstu_pkg.sv */
/*
 * Shared types of the vector store unit
 * Element width and unit opcodes, plus the data and strobe widths
 */
`include "vstu_params.svh"

package vstu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Element width, value is the byte shift
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  // Functional unit targeted by a sequencer request
  typedef enum logic [1:0] {
    VFU_NONE  = 2'd0,
    VFU_ALU   = 2'd1,
    VFU_LOAD  = 2'd2,
    VFU_STORE = 2'd3
  } vfu_e;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [$clog2(`VSTU_NR_VINSN)-1:0] vid_t;
  typedef logic [`VSTU_VL_W-1:0]             vlen_t;
  typedef logic [`VSTU_BYTE_CNT_W-1:0]       byte_cnt_t;

  // One lane word and its byte enables
  typedef logic [`VSTU_ELEN-1:0]       elen_t;
  typedef logic [`VSTU_LANE_BYTES-1:0] lane_strb_t;

  // Full W beat
  typedef logic [8*`VSTU_BEAT_BYTES-1:0] beat_data_t;
  typedef logic [`VSTU_BEAT_BYTES-1:0]   beat_strb_t;

  // One bit per instruction ID
  typedef logic [`VSTU_NR_VINSN-1:0] vinsn_mask_t;

endpackage

/* hdl/vstu_top.sv */
/*
 * Vector store unit top
 * Instruction queue, per-lane spill registers and the W beat builder
 */
`timescale 1ns/1ps
`include "vstu_params.svh"

module vstu_top (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       flush_i,
  // Sequencer request
  input  logic                                       pe_req_valid_i,
  input  vstu_pkg::vid_t                             pe_req_id_i,
  input  vstu_pkg::vfu_e                             pe_req_vfu_i,
  input  vstu_pkg::vlen_t                            pe_req_vl_i,
  input  vstu_pkg::vsew_e                            pe_req_vsew_i,
  input  logic                                       pe_req_vm_i,
  output logic                                       pe_req_ready_o,
  // Lanes
  input  vstu_pkg::elen_t      [`VSTU_NR_LANES-1:0] stu_operand_i,
  input  logic                 [`VSTU_NR_LANES-1:0] stu_operand_valid_i,
  output logic                 [`VSTU_NR_LANES-1:0] stu_operand_ready_o,
  // Mask unit
  input  vstu_pkg::lane_strb_t [`VSTU_NR_LANES-1:0] mask_i,
  input  logic                 [`VSTU_NR_LANES-1:0] mask_valid_i,
  output logic                 [`VSTU_NR_LANES-1:0] mask_ready_o,
  // AXI W
  output vstu_pkg::beat_data_t                       axi_w_data_o,
  output vstu_pkg::beat_strb_t                       axi_w_strb_o,
  output logic                                       axi_w_last_o,
  output logic                                       axi_w_valid_o,
  input  logic                                       axi_w_ready_i,
  // AXI B
  input  logic                                       axi_b_valid_i,
  output logic                                       axi_b_ready_o,
  // Status
  output logic                                       store_pending_o,
  output logic                                       store_complete_o,
  output vstu_pkg::vinsn_mask_t                      pe_resp_vinsn_done_o
);

  // Lane register outputs toward the builder
  vstu_pkg::elen_t      [`VSTU_NR_LANES-1:0] lane_operand;
  vstu_pkg::lane_strb_t [`VSTU_NR_LANES-1:0] lane_mask;
  logic                 [`VSTU_NR_LANES-1:0] lane_operand_valid, lane_mask_valid;
  logic                                      lane_pop;

  // Issue handshake
  logic            issue_valid, issue_vm, issue_done;
  vstu_pkg::vlen_t issue_vl;
  vstu_pkg::vsew_e issue_vsew;

  store_insn_queue u_queue (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .pe_req_valid_i       (pe_req_valid_i),
    .pe_req_id_i          (pe_req_id_i),
    .pe_req_vfu_i         (pe_req_vfu_i),
    .pe_req_vl_i          (pe_req_vl_i),
    .pe_req_vsew_i        (pe_req_vsew_i),
    .pe_req_vm_i          (pe_req_vm_i),
    .pe_req_ready_o       (pe_req_ready_o),
    .issue_valid_o        (issue_valid),
    .issue_vl_o           (issue_vl),
    .issue_vsew_o         (issue_vsew),
    .issue_vm_o           (issue_vm),
    .issue_done_i         (issue_done),
    .b_valid_i            (axi_b_valid_i),
    .b_ready_o            (axi_b_ready_o),
    .store_pending_o      (store_pending_o),
    .store_complete_o     (store_complete_o),
    .pe_resp_vinsn_done_o (pe_resp_vinsn_done_o)
  );

  // One spill register per lane, all drained by the same pop
  for (genvar l = 0; l < `VSTU_NR_LANES; l++) begin : gen_lane
    lane_spill_reg u_spill (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .flush_i         (flush_i),
      .operand_i       (stu_operand_i[l]),
      .mask_i          (mask_i[l]),
      .operand_valid_i (stu_operand_valid_i[l]),
      .mask_valid_i    (mask_valid_i[l]),
      .operand_ready_o (stu_operand_ready_o[l]),
      .mask_ready_o    (mask_ready_o[l]),
      .operand_o       (lane_operand[l]),
      .mask_o          (lane_mask[l]),
      .operand_valid_o (lane_operand_valid[l]),
      .mask_valid_o    (lane_mask_valid[l]),
      .pop_i           (lane_pop)
    );
  end

  w_beat_builder u_builder (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .issue_valid_i        (issue_valid),
    .issue_vl_i           (issue_vl),
    .issue_vsew_i         (issue_vsew),
    .issue_vm_i           (issue_vm),
    .issue_done_o         (issue_done),
    .lane_operand_i       (lane_operand),
    .lane_mask_i          (lane_mask),
    .lane_operand_valid_i (lane_operand_valid),
    .lane_mask_valid_i    (lane_mask_valid),
    .lane_pop_o           (lane_pop),
    .w_data_o             (axi_w_data_o),
    .w_strb_o             (axi_w_strb_o),
    .w_last_o             (axi_w_last_o),
    .w_valid_o            (axi_w_valid_o),
    .w_ready_i            (axi_w_ready_i)
  );

endmodule

/* hdl/w_beat_builder.sv */
/*
 * W beat builder
 * Packs the lane registers into one W beat per handshake and keeps
 * the remaining byte count of the issuing store
 */
`timescale 1ns/1ps
`include "vstu_params.svh"

module w_beat_builder (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Issuing instruction
  input  logic                                       issue_valid_i,
  input  vstu_pkg::vlen_t                            issue_vl_i,
  input  vstu_pkg::vsew_e                            issue_vsew_i,
  input  logic                                       issue_vm_i,
  output logic                                       issue_done_o,
  // Lane registers
  input  vstu_pkg::elen_t      [`VSTU_NR_LANES-1:0] lane_operand_i,
  input  vstu_pkg::lane_strb_t [`VSTU_NR_LANES-1:0] lane_mask_i,
  input  logic                 [`VSTU_NR_LANES-1:0] lane_operand_valid_i,
  input  logic                 [`VSTU_NR_LANES-1:0] lane_mask_valid_i,
  output logic                                       lane_pop_o,
  // W channel
  output vstu_pkg::beat_data_t                       w_data_o,
  output vstu_pkg::beat_strb_t                       w_strb_o,
  output logic                                       w_last_o,
  output logic                                       w_valid_o,
  input  logic                                       w_ready_i
);

  // Bytes still owed by the issuing store
  vstu_pkg::byte_cnt_t rem_q, rem;
  // First beat of the store already sent
  logic                started_q;
  logic                w_hs;

  //////////////////////////////////////////////////////////////////////
  // Byte count
  //////////////////////////////////////////////////////////////////////

  // A fresh store takes its count straight from vl and element width
  assign rem = started_q ? rem_q : (vstu_pkg::byte_cnt_t'(issue_vl_i) << issue_vsew_i);

  assign w_last_o = (rem <= vstu_pkg::byte_cnt_t'(`VSTU_BEAT_BYTES));

  // Every lane word present, and the masks too unless unmasked
  assign w_valid_o = issue_valid_i && (&lane_operand_valid_i) &&
                     (issue_vm_i || (&lane_mask_valid_i));

  assign w_hs         = w_valid_o && w_ready_i;
  assign lane_pop_o   = w_hs;
  assign issue_done_o = w_hs && w_last_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q     <= '0;
      started_q <= 1'b0;
    end else if (w_hs) begin
      // Final beat hands over to the next instruction
      started_q <= !w_last_o;
      rem_q     <= rem - vstu_pkg::byte_cnt_t'(`VSTU_BEAT_BYTES);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Beat assembly
  //////////////////////////////////////////////////////////////////////

  // Sequential map, lane l fills bytes 8l to 8l+7
  always_comb begin
    for (int l = 0; l < `VSTU_NR_LANES; l++) begin
      w_data_o[`VSTU_ELEN*l +: `VSTU_ELEN] = lane_operand_i[l];
    end
  end

  // Strobe on bytes still inside the store, filtered by the mask
  always_comb begin
    for (int k = 0; k < `VSTU_BEAT_BYTES; k++) begin
      w_strb_o[k] = (k < int'(rem)) &&
                    (issue_vm_i ||
                     lane_mask_i[k / `VSTU_LANE_BYTES][k % `VSTU_LANE_BYTES]);
    end
  end

endmodule

/* verif/vstu_asserts.sv */
/*
 * Concurrent checks on the W, B and request handshakes of the store unit
 */
`timescale 1ns/1ps
`include "vstu_params.svh"

module vstu_asserts (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 req_valid_i,
  input vstu_pkg::vfu_e       req_vfu_i,
  input logic                 req_ready_i,
  input vstu_pkg::beat_data_t w_data_i,
  input vstu_pkg::beat_strb_t w_strb_i,
  input logic                 w_last_i,
  input logic                 w_valid_i,
  input logic                 w_ready_i,
  input logic                 b_valid_i,
  input logic                 b_ready_i,
  input logic                 complete_i
);

  localparam int unsigned Depth = `VSTU_INSN_DEPTH;

  int unsigned fail_cnt = 0;
  // Stores accepted and not yet answered on B
  logic [$clog2(Depth):0] pending_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_q
                 + ($clog2(Depth)+1)'(req_valid_i && req_ready_i &&
                                      req_vfu_i == vstu_pkg::VFU_STORE)
                 - ($clog2(Depth)+1)'(b_valid_i && b_ready_i);
    end
  end

  // Stalled beat keeps valid and contents
  a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_i && !w_ready_i |=>
      w_valid_i && $stable(w_data_i) && $stable(w_strb_i) && $stable(w_last_i))
    else begin
      $error("W beat dropped or changed while stalled");
      fail_cnt++;
    end

  // A completion needs a B response and a store still owed
  a_complete_on_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    complete_i |-> b_valid_i && (pending_q != '0))
    else begin
      $error("store completion without a B response or without a pending store");
      fail_cnt++;
    end

  // Full queue refuses requests
  a_full_not_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pending_q == Depth) |-> !req_ready_i)
    else begin
      $error("request ready while four stores are pending");
      fail_cnt++;
    end

endmodule

/* verif/vstu_tb.sv */
/*
 * Testbench of the vector store unit
 * Clock, reset, request and lane stimulus, reference beats,
 * W and completion monitors, watchdog and summary
 */
`timescale 1ns/1ps
`include "vstu_params.svh"

module vstu_tb;

  localparam int NL = `VSTU_NR_LANES;
  localparam int BB = `VSTU_BEAT_BYTES;

  // Expected beat as {last, strobe, data}
  typedef logic [8*BB+BB:0] beat_exp_t;

  logic                          clk_i, rst_ni, flush_i;
  logic                          pe_req_valid_i, pe_req_vm_i, pe_req_ready_o;
  vstu_pkg::vid_t                pe_req_id_i;
  vstu_pkg::vfu_e                pe_req_vfu_i;
  vstu_pkg::vlen_t               pe_req_vl_i;
  vstu_pkg::vsew_e               pe_req_vsew_i;
  vstu_pkg::elen_t      [NL-1:0] stu_operand_i;
  vstu_pkg::lane_strb_t [NL-1:0] mask_i;
  logic                 [NL-1:0] stu_operand_valid_i, stu_operand_ready_o;
  logic                 [NL-1:0] mask_valid_i, mask_ready_o;
  vstu_pkg::beat_data_t          axi_w_data_o;
  vstu_pkg::beat_strb_t          axi_w_strb_o;
  logic                          axi_w_last_o, axi_w_valid_o, axi_w_ready_i;
  logic                          axi_b_valid_i, axi_b_ready_o;
  logic                          store_pending_o, store_complete_o;
  vstu_pkg::vinsn_mask_t         pe_resp_vinsn_done_o;

  // Scoreboard
  beat_exp_t             exp_beats [$];
  vstu_pkg::vid_t        exp_ids [$];
  vstu_pkg::vinsn_mask_t exp_done = '0;
  logic [31:0]           lcg_state = 32'd84936;
  int                    errors = 0;
  int                    passes = 0;
  int                    fails = 0;
  int                    stores_issued = 0;
  int                    b_credit = 0;
  logic                  w_stall = 1'b0;
  logic                  b_enable = 1'b1;

  vstu_top dut0 (.*);

  bind vstu_top vstu_asserts u_asserts (
    .clk_i (clk_i), .rst_ni (rst_ni), .req_valid_i (pe_req_valid_i),
    .req_vfu_i (pe_req_vfu_i), .req_ready_i (pe_req_ready_o),
    .w_data_i (axi_w_data_o), .w_strb_i (axi_w_strb_o), .w_last_i (axi_w_last_o),
    .w_valid_i (axi_w_valid_o), .w_ready_i (axi_w_ready_i),
    .b_valid_i (axi_b_valid_i), .b_ready_i (axi_b_ready_o),
    .complete_i (store_complete_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[30:16]) % n;
  endfunction

  // Reference beat built byte by byte from lane k/8 with strobes from count and mask
  function automatic beat_exp_t ref_beat(input int rem, input logic vm,
      input vstu_pkg::elen_t [NL-1:0] words, input vstu_pkg::lane_strb_t [NL-1:0] masks);
    logic [8*BB-1:0] data;
    logic [BB-1:0]   strb;
    for (int k = 0; k < BB; k++) begin
      data[8*k +: 8] = words[k/8][8*(k%8) +: 8];
      strb[k]        = (k < rem) && (vm || masks[k/8][k%8]);
    end
    return {(rem <= BB), strb, data};
  endfunction

  task automatic check_value(input string name, input logic [8*BB-1:0] got,
                             input logic [8*BB-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) begin
      passes++;
      $display("test %s: ok", name);
    end else begin
      fails++;
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////

  task automatic send_req(input int id, input vstu_pkg::vfu_e vfu, input int vl,
                          input vstu_pkg::vsew_e vsew, input logic vm);
    @(posedge clk_i);
    pe_req_valid_i <= 1'b1;
    pe_req_id_i    <= vstu_pkg::vid_t'(id);
    pe_req_vfu_i   <= vfu;
    pe_req_vl_i    <= vstu_pkg::vlen_t'(vl);
    pe_req_vsew_i  <= vsew;
    pe_req_vm_i    <= vm;
    do @(posedge clk_i); while (!pe_req_ready_o);
    pe_req_valid_i <= 1'b0;
    if (vfu == vstu_pkg::VFU_STORE) begin
      exp_ids.push_back(vstu_pkg::vid_t'(id));
      stores_issued++;
    end
  endtask

  task automatic put_operands(input vstu_pkg::elen_t [NL-1:0] words);
    @(posedge clk_i);
    stu_operand_i       <= words;
    stu_operand_valid_i <= '1;
    do @(posedge clk_i); while (!(&stu_operand_ready_o));
    stu_operand_valid_i <= '0;
  endtask

  task automatic put_masks(input vstu_pkg::lane_strb_t [NL-1:0] masks);
    @(posedge clk_i);
    mask_i       <= masks;
    mask_valid_i <= '1;
    do @(posedge clk_i); while (!(&mask_ready_o));
    mask_valid_i <= '0;
  endtask

  // Lane side of one store with expected beats queued ahead of the data
  task automatic feed_store(input int vl, input vstu_pkg::vsew_e vsew, input logic vm,
                            input int mask_delay);
    int                            rem;
    vstu_pkg::elen_t      [NL-1:0] words;
    vstu_pkg::lane_strb_t [NL-1:0] masks;
    rem = vl << int'(vsew);
    while (rem > 0) begin
      for (int l = 0; l < NL; l++) begin
        words[l] = {lcg_next(), lcg_next()};
        masks[l] = vstu_pkg::lane_strb_t'(lcg_next());
      end
      exp_beats.push_back(ref_beat(rem, vm, words, masks));
      repeat (rand_below(3)) @(posedge clk_i);
      put_operands(words);
      if (!vm) begin
        // No beat may leave before the masks land
        repeat (mask_delay) begin
          @(posedge clk_i);
          check_value("axi_w_valid_o", axi_w_valid_o, 1'b0);
        end
        put_masks(masks);
      end
      rem -= BB;
    end
  endtask

  task automatic wait_idle();
    do @(posedge clk_i);
    while (exp_beats.size() != 0 || exp_ids.size() != 0 || store_pending_o);
    @(posedge clk_i);
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI slave with W ready stalls and B responses after each burst
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : axi_slave
    // Ready only for bursts sent and not yet answered
    if (rst_ni) check_value("axi_b_ready_o", axi_b_ready_o, b_credit > 0);
    if (axi_w_valid_o && axi_w_ready_i && axi_w_last_o) b_credit++;
    if (axi_b_valid_i && axi_b_ready_o) b_credit--;
    axi_w_ready_i <= w_stall ? (rand_below(3) != 0) : 1'b1;
    // Valid holds until taken
    if (!axi_b_valid_i || axi_b_ready_o)
      axi_b_valid_i <= b_enable && (b_credit > 0) && (rand_below(4) == 0);
  end

  //////////////////////////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : w_monitor
    beat_exp_t exp;
    if (rst_ni && axi_w_valid_o && axi_w_ready_i) begin
      if (exp_beats.size() == 0) begin
        $display("W beat accepted while no beat was expected");
        errors++;
      end else begin
        exp = exp_beats.pop_front();
        check_value("axi_w_data_o", axi_w_data_o, exp[8*BB-1:0]);
        check_value("axi_w_strb_o", axi_w_strb_o, exp[8*BB +: BB]);
        check_value("axi_w_last_o", axi_w_last_o, exp[8*BB+BB]);
      end
    end
  end

  // Completions in request order with the done bit one cycle later
  always @(posedge clk_i) begin : completion_monitor
    if (rst_ni) begin
      check_value("pe_resp_vinsn_done_o", pe_resp_vinsn_done_o, exp_done);
      exp_done = '0;
      if (store_complete_o) begin
        if (exp_ids.size() == 0) begin
          $display("store completed while none was outstanding");
          errors++;
        end else begin
          exp_done = vstu_pkg::vinsn_mask_t'(1) << exp_ids.pop_front();
        end
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 200 * stores_issued + 500) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("watchdog: run did not finish within %0d cycles", cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    int e;
    rst_ni              = 1'b0;
    flush_i             = 1'b0;
    pe_req_valid_i      = 1'b0;
    pe_req_id_i         = '0;
    pe_req_vfu_i        = vstu_pkg::VFU_NONE;
    pe_req_vl_i         = '0;
    pe_req_vsew_i       = vstu_pkg::EW8;
    pe_req_vm_i         = 1'b0;
    stu_operand_i       = '0;
    stu_operand_valid_i = '0;
    mask_i              = '0;
    mask_valid_i        = '0;
    axi_w_ready_i       = 1'b0;
    axi_b_valid_i       = 1'b0;

    // Reset values
    e = errors;
    repeat (10) @(posedge clk_i);
    check_value("pe_req_ready_o", pe_req_ready_o, 1'b1);
    check_value("axi_w_valid_o", axi_w_valid_o, 1'b0);
    check_value("axi_b_ready_o", axi_b_ready_o, 1'b0);
    check_value("store_pending_o", store_pending_o, 1'b0);
    check_value("store_complete_o", store_complete_o, 1'b0);
    check_value("pe_resp_vinsn_done_o", pe_resp_vinsn_done_o, '0);
    rst_ni <= 1'b1;
    end_test("reset", e);

    // Whole beats of byte and doubleword elements
    e = errors;
    send_req(1, vstu_pkg::VFU_STORE, 32, vstu_pkg::EW8, 1'b1);
    feed_store(32, vstu_pkg::EW8, 1'b1, 0);
    send_req(2, vstu_pkg::VFU_STORE, 16, vstu_pkg::EW64, 1'b1);
    feed_store(16, vstu_pkg::EW64, 1'b1, 0);
    wait_idle();
    end_test("full beats", e);

    // Partial final beat
    e = errors;
    send_req(3, vstu_pkg::VFU_STORE, 13, vstu_pkg::EW32, 1'b1);
    feed_store(13, vstu_pkg::EW32, 1'b1, 0);
    send_req(4, vstu_pkg::VFU_STORE, 5, vstu_pkg::EW16, 1'b1);
    feed_store(5, vstu_pkg::EW16, 1'b1, 0);
    wait_idle();
    end_test("partial beat", e);

    // Masked store with late masks
    e = errors;
    send_req(5, vstu_pkg::VFU_STORE, 12, vstu_pkg::EW64, 1'b0);
    feed_store(12, vstu_pkg::EW64, 1'b0, 3);
    wait_idle();
    end_test("masked store", e);

    // Four in flight under W stalls with B held back until all are sent
    e = errors;
    w_stall  <= 1'b1;
    b_enable <= 1'b0;
    fork
      begin
        for (int i = 0; i < 4; i++)
          send_req(4 + i, vstu_pkg::VFU_STORE, 9 + 7*i, vstu_pkg::vsew_e'(i), i != 2);
      end
      begin
        for (int i = 0; i < 4; i++)
          feed_store(9 + 7*i, vstu_pkg::vsew_e'(i), i != 2, 0);
      end
    join
    do @(posedge clk_i); while (exp_beats.size() != 0);
    repeat (2) @(posedge clk_i);
    check_value("pe_req_ready_o", pe_req_ready_o, 1'b0);
    check_value("store_pending_o", store_pending_o, 1'b1);
    b_enable <= 1'b1;
    wait_idle();
    w_stall <= 1'b0;
    end_test("four in flight", e);

    // Request for another unit is ignored
    e = errors;
    send_req(6, vstu_pkg::VFU_ALU, 8, vstu_pkg::EW64, 1'b1);
    repeat (20) begin
      @(posedge clk_i);
      check_value("store_pending_o", store_pending_o, 1'b0);
    end
    end_test("other unit", e);

    // Flush drops stale operands
    e = errors;
    put_operands({lcg_next(), lcg_next(), lcg_next(), lcg_next(),
                  lcg_next(), lcg_next(), lcg_next(), lcg_next()});
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    send_req(7, vstu_pkg::VFU_STORE, 4, vstu_pkg::EW64, 1'b1);
    feed_store(4, vstu_pkg::EW64, 1'b1, 0);
    wait_idle();
    end_test("flush", e);

    errors += dut0.u_asserts.fail_cnt;
    $display("tests passed: %0d, tests failed: %0d, errors: %0d, assertion failures: %0d",
             passes, fails, errors, dut0.u_asserts.fail_cnt);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
